//--- design/chdr_conv_pkg.sv
// chdr sc16 to sc8 converter shared definitions
// stream word types, settings bus, converter states and sample rounding
package chdr_conv_pkg;

   // one stream word and the sample formats packed inside it
   typedef logic [63:0] chdr_word_t;
   typedef logic [31:0] sc16_t;
   typedef logic [15:0] sc8_t;

   // header fields
   typedef logic [15:0] chdr_len_t;
   typedef logic [15:0] sid_addr_t;

   typedef struct packed {
      chdr_word_t tdata;
      logic       tlast;
   } axis_beat_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } setting_bus_t;

   typedef enum logic [1:0] {
      HEADER = 2'd0,
      TIME   = 2'd1,
      ODD    = 2'd2,
      EVEN   = 2'd3
   } conv_state_e;

   // header flag for a timestamp word after the header
   localparam int HDR_HAS_TIME_BIT = 61;

   // round half up to 8 bits, clamp at +127 when a positive value wraps
   function automatic logic [7:0] round_sc16_to_sc8(input logic [15:0] comp);
      logic [15:0] sum;
      sum = comp + 16'd128;
      if (!comp[15] && sum[15]) begin
         return 8'h7f;
      end
      return sum[15:8];
   endfunction

endpackage

//--- design/setting_reg.sv
// settings register
// loads the low data bits of the settings bus on a strobe to its address
`timescale 1ns/1ps

module setting_reg #(
   parameter logic [7:0] ADDR  = 8'h00,
   parameter int         WIDTH = 32
) (
   input  logic                       clk,
   input  logic                       reset,
   input  chdr_conv_pkg::setting_bus_t i_set,
   output logic [WIDTH-1:0]           o_value
);

   logic hit;

   assign hit = i_set.stb && (i_set.addr == ADDR);

   always_ff @(posedge clk) begin
      if (reset) begin
         o_value <= '0;
      end else if (hit) begin
         o_value <= i_set.data[WIDTH-1:0];
      end
   end

endmodule

//--- design/axis_reg_slice.sv
// stream register slice
// one registered stage plus a skid entry, full rate with registered ready
`timescale 1ns/1ps

module axis_reg_slice (
   input  logic                      clk,
   input  logic                      reset,
   input  chdr_conv_pkg::axis_beat_t i_beat,
   input  logic                      i_valid,
   output logic                      o_ready,
   output chdr_conv_pkg::axis_beat_t o_beat,
   output logic                      o_valid,
   input  logic                      i_ready
);

   chdr_conv_pkg::axis_beat_t main_beat;
   chdr_conv_pkg::axis_beat_t skid_beat;
   logic                      main_valid;
   logic                      skid_valid;
   logic                      in_fire;
   logic                      main_load;

   // skid entry only fills while the output is stalled
   assign o_ready   = !skid_valid;
   assign in_fire   = i_valid && o_ready;
   assign main_load = !main_valid || i_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else if (main_load) begin
         // skid drains first to keep order
         main_valid <= skid_valid || in_fire;
         skid_valid <= 1'b0;
      end else if (in_fire) begin
         skid_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (main_load) begin
         if (skid_valid) begin
            main_beat <= skid_beat;
         end else if (in_fire) begin
            main_beat <= i_beat;
         end
      end else if (in_fire) begin
         skid_beat <= i_beat;
      end
   end

   assign o_beat  = main_beat;
   assign o_valid = main_valid;

endmodule

//--- design/chdr_16sc_to_8sc.sv
// chdr sc16 to sc8 converter
// rounds samples to 8 bits, packs two payload lines into one,
// rewrites the header length and optionally swaps the stream id
`timescale 1ns/1ps

module chdr_16sc_to_8sc #(
   parameter logic [7:0] BASE = 8'h00
) (
   input  logic                        clk,
   input  logic                        reset,
   input  chdr_conv_pkg::setting_bus_t i_set,
   input  chdr_conv_pkg::axis_beat_t   i_beat,
   input  logic                        i_valid,
   output logic                        o_ready,
   output chdr_conv_pkg::axis_beat_t   o_beat,
   output logic                        o_valid,
   input  logic                        i_ready
);

   chdr_conv_pkg::conv_state_e state;
   chdr_conv_pkg::chdr_word_t  hold_word;
   chdr_conv_pkg::chdr_word_t  out_word;

   logic [16:0]                sid_cfg;
   logic                       sid_enable;
   chdr_conv_pkg::sid_addr_t   new_dst;
   chdr_conv_pkg::sid_addr_t   old_dst;

   logic                       has_time;
   chdr_conv_pkg::chdr_len_t   hdr_bytes;
   chdr_conv_pkg::chdr_len_t   in_len;
   chdr_conv_pkg::chdr_len_t   out_len;

   logic                       in_fire;
   logic [31:0]                cur_packed;
   logic [31:0]                hold_packed;

   // rounds both samples of one line into 32 bits
   function automatic logic [31:0] pack_line(input chdr_conv_pkg::chdr_word_t w);
      chdr_conv_pkg::sc16_t s0;
      chdr_conv_pkg::sc16_t s1;
      chdr_conv_pkg::sc8_t  r0;
      chdr_conv_pkg::sc8_t  r1;
      s0 = w[63:32];
      s1 = w[31:0];
      r0 = {chdr_conv_pkg::round_sc16_to_sc8(s0[31:16]),
            chdr_conv_pkg::round_sc16_to_sc8(s0[15:0])};
      r1 = {chdr_conv_pkg::round_sc16_to_sc8(s1[31:16]),
            chdr_conv_pkg::round_sc16_to_sc8(s1[15:0])};
      return {r0, r1};
   endfunction

   // enable in bit 16, new destination below
   setting_reg #(
      .ADDR  (BASE),
      .WIDTH (17)
   ) new_dst_reg (
      .clk     (clk),
      .reset   (reset),
      .i_set   (i_set),
      .o_value (sid_cfg)
   );

   assign sid_enable = sid_cfg[16];
   assign new_dst    = sid_cfg[15:0];
   assign old_dst    = i_beat.tdata[15:0];

   // length fields only mean something on the header word
   assign has_time  = i_beat.tdata[chdr_conv_pkg::HDR_HAS_TIME_BIT];
   assign hdr_bytes = has_time ? 16'd16 : 16'd8;
   assign in_len    = i_beat.tdata[47:32];
   assign out_len   = hdr_bytes + ((in_len - hdr_bytes) >> 1);

   assign in_fire = i_valid && o_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= chdr_conv_pkg::HEADER;
      end else if (in_fire) begin
         case (state)
            chdr_conv_pkg::HEADER: begin
               if (i_beat.tlast) begin
                  state <= chdr_conv_pkg::HEADER;
               end else if (has_time) begin
                  state <= chdr_conv_pkg::TIME;
               end else begin
                  state <= chdr_conv_pkg::ODD;
               end
            end
            chdr_conv_pkg::TIME: begin
               state <= i_beat.tlast ? chdr_conv_pkg::HEADER : chdr_conv_pkg::ODD;
            end
            chdr_conv_pkg::ODD: begin
               state <= i_beat.tlast ? chdr_conv_pkg::HEADER : chdr_conv_pkg::EVEN;
            end
            chdr_conv_pkg::EVEN: begin
               state <= i_beat.tlast ? chdr_conv_pkg::HEADER : chdr_conv_pkg::ODD;
            end
            default: begin
               state <= chdr_conv_pkg::HEADER;
            end
         endcase
      end
   end

   // previous accepted word, the odd line is paired with the next one
   always_ff @(posedge clk) begin
      if (in_fire) begin
         hold_word <= i_beat.tdata;
      end
   end

   assign cur_packed  = pack_line(i_beat.tdata);
   assign hold_packed = pack_line(hold_word);

   always_comb begin
      case (state)
         chdr_conv_pkg::HEADER: begin
            if (sid_enable) begin
               out_word = {i_beat.tdata[63:48], out_len, old_dst, new_dst};
            end else begin
               out_word = {i_beat.tdata[63:48], out_len, i_beat.tdata[31:0]};
            end
         end
         chdr_conv_pkg::TIME: begin
            out_word = i_beat.tdata;
         end
         // last line of an odd count, lower half is don't care
         chdr_conv_pkg::ODD: begin
            out_word = {cur_packed, hold_packed};
         end
         chdr_conv_pkg::EVEN: begin
            out_word = {hold_packed, cur_packed};
         end
         default: begin
            out_word = i_beat.tdata;
         end
      endcase
   end

   assign o_beat.tdata = out_word;
   assign o_beat.tlast = i_beat.tlast;

   // odd lines are swallowed into the hold register unless they end the packet
   assign o_valid = i_valid && ((state != chdr_conv_pkg::ODD) || i_beat.tlast);
   assign o_ready = i_ready || ((state == chdr_conv_pkg::ODD) && !i_beat.tlast);

endmodule

//--- design/chdr_sc16_to_sc8_top.sv
// chdr sc16 to sc8 top level
// input register slice, converter, output register slice
`timescale 1ns/1ps

module chdr_sc16_to_sc8_top #(
   parameter logic [7:0] SR_BASE = 8'h00
) (
   input  logic                        clk,
   input  logic                        reset,

   // sc16 stream in
   input  chdr_conv_pkg::chdr_word_t   i_tdata,
   input  logic                        i_tlast,
   input  logic                        i_tvalid,
   output logic                        o_tready_in,

   // sc8 stream out
   output chdr_conv_pkg::chdr_word_t   o_tdata,
   output logic                        o_tlast,
   output logic                        o_tvalid,
   input  logic                        i_tready_out,

   input  chdr_conv_pkg::setting_bus_t i_set
);

   chdr_conv_pkg::axis_beat_t in_beat;
   chdr_conv_pkg::axis_beat_t conv_in_beat;
   logic                      conv_in_valid;
   logic                      conv_in_ready;
   chdr_conv_pkg::axis_beat_t conv_out_beat;
   logic                      conv_out_valid;
   logic                      conv_out_ready;
   chdr_conv_pkg::axis_beat_t out_beat;

   assign in_beat.tdata = i_tdata;
   assign in_beat.tlast = i_tlast;

   axis_reg_slice slice_in (
      .clk     (clk),
      .reset   (reset),
      .i_beat  (in_beat),
      .i_valid (i_tvalid),
      .o_ready (o_tready_in),
      .o_beat  (conv_in_beat),
      .o_valid (conv_in_valid),
      .i_ready (conv_in_ready)
   );

   chdr_16sc_to_8sc #(
      .BASE (SR_BASE)
   ) conv (
      .clk     (clk),
      .reset   (reset),
      .i_set   (i_set),
      .i_beat  (conv_in_beat),
      .i_valid (conv_in_valid),
      .o_ready (conv_in_ready),
      .o_beat  (conv_out_beat),
      .o_valid (conv_out_valid),
      .i_ready (conv_out_ready)
   );

   axis_reg_slice slice_out (
      .clk     (clk),
      .reset   (reset),
      .i_beat  (conv_out_beat),
      .i_valid (conv_out_valid),
      .o_ready (conv_out_ready),
      .o_beat  (out_beat),
      .o_valid (o_tvalid),
      .i_ready (i_tready_out)
   );

   assign o_tdata = out_beat.tdata;
   assign o_tlast = out_beat.tlast;

endmodule

//--- dv/chdr_conv_properties.sv
// output stream checks for the chdr sc16 to sc8 top level
// valid low after reset, data held steady while stalled
`timescale 1ns/1ps

module chdr_conv_properties (
   input logic                      clk,
   input logic                      reset,
   input chdr_conv_pkg::chdr_word_t o_tdata,
   input logic                      o_tlast,
   input logic                      o_tvalid,
   input logic                      i_tready_out
);

   // failures seen so far, read by the testbench
   int fail_count = 0;

   property valid_low_after_reset;
      @(posedge clk) reset |=> !o_tvalid;
   endproperty

   property beat_held_while_stalled;
      @(posedge clk) disable iff (reset)
         (o_tvalid && !i_tready_out) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast));
   endproperty

   valid_low_after_reset_a : assert property (valid_low_after_reset)
      else begin
         fail_count++;
         $error("o_tvalid high in the cycle after reset");
      end

   beat_held_while_stalled_a : assert property (beat_held_while_stalled)
      else begin
         fail_count++;
         $error("output beat changed or dropped while i_tready_out was low");
      end

endmodule

bind chdr_sc16_to_sc8_top chdr_conv_properties props_inst (
   .clk          (clk),
   .reset        (reset),
   .o_tdata      (o_tdata),
   .o_tlast      (o_tlast),
   .o_tvalid     (o_tvalid),
   .i_tready_out (i_tready_out)
);

//--- dv/tb_chdr_sc16_to_sc8.sv
// testbench for the chdr sc16 to sc8 converter top level
// directed packets against a reference model, with back-pressure
`timescale 1ns/1ps

module tb_chdr_sc16_to_sc8;

   localparam int         CLK_PERIOD  = 4;
   localparam logic [7:0] SR_BASE     = 8'h40;
   // beats driven by all tests together
   localparam int         TOTAL_BEATS = 9 + 8 + 6 + 3 + 9 + 25;
   localparam int         KIND_HEADER = 0;
   localparam int         KIND_WORD   = 1;
   localparam int         KIND_FULL   = 2;
   localparam int         KIND_HALF   = 3;
   localparam logic [63:0] CORNER_A   = 64'h7fff_8000_0080_ff7f;
   localparam logic [63:0] CORNER_B   = 64'hff7f_0080_8000_7fff;

   logic                        clk;
   logic                        reset;
   chdr_conv_pkg::chdr_word_t   i_tdata;
   logic                        i_tlast;
   logic                        i_tvalid;
   logic                        o_tready_in;
   chdr_conv_pkg::chdr_word_t   o_tdata;
   logic                        o_tlast;
   logic                        o_tvalid;
   logic                        i_tready_out;
   chdr_conv_pkg::setting_bus_t i_set;

   chdr_conv_pkg::chdr_word_t in_word[$];
   logic                      in_last[$];
   chdr_conv_pkg::chdr_word_t exp_word[$];
   int                        exp_kind[$];
   logic                      exp_last[$];
   chdr_conv_pkg::chdr_word_t got_word[$];
   logic                      got_last[$];

   int                        value_errors = 0;
   int                        stream_errors = 0;
   logic                      bp_on = 1'b0;
   logic                      model_sid_en = 1'b0;
   chdr_conv_pkg::sid_addr_t  model_dst = '0;

   chdr_sc16_to_sc8_top #(
      .SR_BASE (SR_BASE)
   ) chdr_sc16_to_sc8_top_inst (
      .clk          (clk),
      .reset        (reset),
      .i_tdata      (i_tdata),
      .i_tlast      (i_tlast),
      .i_tvalid     (i_tvalid),
      .o_tready_in  (o_tready_in),
      .o_tdata      (o_tdata),
      .o_tlast      (o_tlast),
      .o_tvalid     (o_tvalid),
      .i_tready_out (i_tready_out),
      .i_set        (i_set)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // downstream ready, random only during the back-pressure test
   always @(posedge clk) begin
      #0.5;
      if (bp_on) begin
         i_tready_out = (($urandom % 2) == 1);
      end else begin
         i_tready_out = 1'b1;
      end
   end

   // values are stable at the falling edge, transfer happens at the next rise
   always @(negedge clk) begin
      if (!reset && o_tvalid && i_tready_out) begin
         got_word.push_back(o_tdata);
         got_last.push_back(o_tlast);
      end
   end

   // signed add of one half lsb, floor shift, clamp at +127
   function automatic logic [7:0] ref_round(input logic [15:0] comp);
      int v;
      v = ($signed(comp) + 128) >>> 8;
      if (v > 127) begin
         v = 127;
      end
      return v[7:0];
   endfunction

   function automatic logic [31:0] ref_line(input chdr_conv_pkg::chdr_word_t w);
      return {ref_round(w[63:48]), ref_round(w[47:32]), ref_round(w[31:16]), ref_round(w[15:0])};
   endfunction

   task automatic compare_word(input string test_name, input string what,
                               input chdr_conv_pkg::chdr_word_t exp_val,
                               input chdr_conv_pkg::chdr_word_t act_val);
      if (act_val !== exp_val) begin
         value_errors++;
         $display("Error %s: %s expected %h, actual %h", test_name, what, exp_val, act_val);
      end
   endtask

   task automatic compare_sample(input string test_name, input string what,
                                 input chdr_conv_pkg::sc8_t exp_val,
                                 input chdr_conv_pkg::sc8_t act_val);
      if (act_val !== exp_val) begin
         value_errors++;
         $display("Error %s: %s expected %h, actual %h", test_name, what, exp_val, act_val);
      end
   endtask

   task automatic compare_len(input string test_name, input string what,
                              input chdr_conv_pkg::chdr_len_t exp_val,
                              input chdr_conv_pkg::chdr_len_t act_val);
      if (act_val !== exp_val) begin
         value_errors++;
         $display("Error %s: %s expected %0d, actual %0d", test_name, what, exp_val, act_val);
      end
   endtask

   task automatic compare_flag(input string test_name, input string what,
                               input logic exp_val, input logic act_val);
      if (act_val !== exp_val) begin
         value_errors++;
         $display("Error %s: %s expected %b, actual %b", test_name, what, exp_val, act_val);
      end
   endtask

   task automatic push_beat(input chdr_conv_pkg::chdr_word_t w, input logic last);
      in_word.push_back(w);
      in_last.push_back(last);
   endtask

   task automatic push_expected(input chdr_conv_pkg::chdr_word_t w, input int kind,
                                input logic last);
      exp_word.push_back(w);
      exp_kind.push_back(kind);
      exp_last.push_back(last);
   endtask

   // appends one input packet and the output it should turn into
   task automatic build_packet(input logic with_time, input int n_lines, input logic corners);
      chdr_conv_pkg::chdr_word_t hdr;
      chdr_conv_pkg::chdr_word_t word;
      chdr_conv_pkg::chdr_word_t prev;
      chdr_conv_pkg::chdr_len_t  in_len;
      chdr_conv_pkg::chdr_len_t  out_len;
      logic [31:0]               seq;
      logic [31:0]               sid;
      int                        hdr_bytes;
      hdr_bytes = with_time ? 16 : 8;
      in_len = chdr_conv_pkg::chdr_len_t'(hdr_bytes + 8 * n_lines);
      // every 8 byte sc16 line leaves 4 bytes of sc8 samples
      out_len = chdr_conv_pkg::chdr_len_t'(hdr_bytes + 4 * n_lines);
      seq = $urandom;
      sid = $urandom;
      prev = '0;
      hdr = {2'b00, with_time, 1'b0, seq[11:0], in_len, sid};
      push_beat(hdr, 1'b0);
      if (model_sid_en) begin
         push_expected({hdr[63:48], out_len, hdr[15:0], model_dst}, KIND_HEADER, 1'b0);
      end else begin
         push_expected({hdr[63:48], out_len, hdr[31:0]}, KIND_HEADER, 1'b0);
      end
      if (with_time) begin
         word = {$urandom, $urandom};
         push_beat(word, 1'b0);
         push_expected(word, KIND_WORD, 1'b0);
      end
      for (int i = 0; i < n_lines; i++) begin
         if (corners) begin
            word = (i % 2 == 0) ? CORNER_A : CORNER_B;
         end else begin
            word = {$urandom, $urandom};
         end
         push_beat(word, i == n_lines - 1);
         if (i % 2 == 1) begin
            push_expected({ref_line(prev), ref_line(word)}, KIND_FULL, i == n_lines - 1);
         end else if (i == n_lines - 1) begin
            push_expected({ref_line(word), 32'h0}, KIND_HALF, 1'b1);
         end
         prev = word;
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      i_set.stb = 1'b1;
      i_set.addr = addr;
      i_set.data = data;
      if (addr == SR_BASE) begin
         model_sid_en = data[16];
         model_dst = data[15:0];
      end
      @(posedge clk);
      #0.5;
      i_set = '0;
   endtask

   task automatic send_stream();
      for (int i = 0; i < in_word.size(); i++) begin
         i_tdata = in_word[i];
         i_tlast = in_last[i];
         i_tvalid = 1'b1;
         @(negedge clk);
         // with downstream always ready the input side never stalls
         if (!bp_on && !o_tready_in) begin
            stream_errors++;
            $display("o_tready_in went low although the output was never stalled");
         end
         while (!o_tready_in) begin
            @(negedge clk);
         end
         @(posedge clk);
         #0.5;
      end
      i_tvalid = 1'b0;
      in_word.delete();
      in_last.delete();
   endtask

   // waits for all expected beats, then checks them field by field
   task automatic check_output(input string test_name);
      int n;
      while (got_word.size() < exp_word.size()) begin
         @(posedge clk);
      end
      repeat (8) @(posedge clk);
      #0.5;
      if (got_word.size() != exp_word.size()) begin
         stream_errors++;
         $display("%s: expected %0d output beats but received %0d", test_name,
                  exp_word.size(), got_word.size());
      end
      n = (got_word.size() < exp_word.size()) ? got_word.size() : exp_word.size();
      for (int i = 0; i < n; i++) begin
         case (exp_kind[i])
            KIND_HEADER: begin
               compare_len(test_name, "header length", exp_word[i][47:32], got_word[i][47:32]);
               compare_word(test_name, "header", exp_word[i], got_word[i]);
            end
            KIND_WORD: begin
               compare_word(test_name, "timestamp", exp_word[i], got_word[i]);
            end
            default: begin
               compare_sample(test_name, "sample 0", exp_word[i][63:48], got_word[i][63:48]);
               compare_sample(test_name, "sample 1", exp_word[i][47:32], got_word[i][47:32]);
               if (exp_kind[i] == KIND_FULL) begin
                  compare_sample(test_name, "sample 2", exp_word[i][31:16], got_word[i][31:16]);
                  compare_sample(test_name, "sample 3", exp_word[i][15:0], got_word[i][15:0]);
               end
            end
         endcase
         compare_flag(test_name, "tlast", exp_last[i], got_last[i]);
      end
      exp_word.delete();
      exp_kind.delete();
      exp_last.delete();
      got_word.delete();
      got_last.delete();
   endtask

   task automatic test_plain_even();
      build_packet(1'b0, 8, 1'b0);
      send_stream();
      check_output("plain_even");
   endtask

   task automatic test_timestamp();
      build_packet(1'b1, 6, 1'b0);
      send_stream();
      check_output("timestamp");
   endtask

   task automatic test_odd_lines();
      build_packet(1'b0, 5, 1'b0);
      send_stream();
      check_output("odd_lines");
   endtask

   task automatic test_round_corners();
      build_packet(1'b0, 2, 1'b1);
      send_stream();
      check_output("round_corners");
   endtask

   task automatic test_sid_rewrite();
      write_setting(SR_BASE, {15'd0, 1'b1, 16'hbeef});
      build_packet(1'b0, 2, 1'b0);
      send_stream();
      check_output("sid_enable");
      // another address must leave the swap as it was
      write_setting(8'h41, {15'd0, 1'b1, 16'h1234});
      build_packet(1'b0, 2, 1'b0);
      send_stream();
      check_output("sid_other_addr");
      write_setting(SR_BASE, 32'h0);
      build_packet(1'b0, 2, 1'b0);
      send_stream();
      check_output("sid_disable");
   endtask

   task automatic test_backpressure();
      bp_on = 1'b1;
      build_packet(1'b0, 4, 1'b0);
      build_packet(1'b0, 7, 1'b0);
      build_packet(1'b1, 3, 1'b0);
      build_packet(1'b0, 6, 1'b0);
      send_stream();
      check_output("backpressure");
      bp_on = 1'b0;
   endtask

   initial begin
      #((20 * TOTAL_BEATS + 5) * CLK_PERIOD);
      $display("timeout: the DUT stopped producing the expected output beats");
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      void'($urandom(32'hb095));
      clk = 1'b0;
      reset = 1'b1;
      i_tdata = '0;
      i_tlast = 1'b0;
      i_tvalid = 1'b0;
      i_tready_out = 1'b1;
      i_set = '0;
      repeat (5) @(posedge clk);
      #0.5;
      reset = 1'b0;
      test_plain_even();
      test_timestamp();
      test_odd_lines();
      test_round_corners();
      test_sid_rewrite();
      test_backpressure();
      $display("value errors: %0d, stream errors: %0d, assertion errors: %0d", value_errors,
               stream_errors, chdr_sc16_to_sc8_top_inst.props_inst.fail_count);
      if (value_errors == 0 && stream_errors == 0 &&
          chdr_sc16_to_sc8_top_inst.props_inst.fail_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- project.f
design/chdr_conv_pkg.sv
design/setting_reg.sv
design/axis_reg_slice.sv
design/chdr_16sc_to_8sc.sv
design/chdr_sc16_to_sc8_top.sv
dv/chdr_conv_properties.sv
dv/tb_chdr_sc16_to_sc8.sv

//--- run_sim.sh
#!/bin/sh
# build and run the chdr sc16 to sc8 converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_chdr_sc16_to_sc8 \
   -Mdir obj_dir \
   -f project.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_chdr_sc16_to_sc8)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^PASS: all tests$"; then
   exit 0
fi

echo "simulation did not report a pass"
exit 1
